/* hw/cluster_periph_pkg.sv */
/*
 * cluster peripheral definitions
 * bus widths, address map, register word indices and event bit positions
 * shared by the peripheral demux and the three peripheral units
 */
package cluster_periph_pkg;

  // peripheral bus
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // address fields
  localparam int unsigned UNIT_SEL_LSB = 10;
  localparam int unsigned REG_IDX_LSB  = 2;

  typedef logic [1:0] unit_sel_t;
  typedef logic [5:0] reg_idx_t;

  localparam unit_sel_t UNIT_CTRL  = 2'd0;
  localparam unit_sel_t UNIT_TIMER = 2'd1;
  localparam unit_sel_t UNIT_EU    = 2'd2;

  // control unit words
  localparam reg_idx_t CTRL_EOC       = 6'd0;
  localparam reg_idx_t CTRL_FETCH_EN  = 6'd2;
  localparam reg_idx_t CTRL_BOOT_BASE = 6'd16;

  // timer words, bit 0 of cfg enables counting
  localparam reg_idx_t TMR_CFG = 6'd0;
  localparam reg_idx_t TMR_CNT = 6'd1;
  localparam reg_idx_t TMR_CMP = 6'd2;

  // event unit words
  localparam reg_idx_t EU_MASK_BASE = 6'd0;
  localparam reg_idx_t EU_BUF_BASE  = 6'd8;
  localparam reg_idx_t EU_SW_EVT    = 6'd16;
  localparam reg_idx_t EU_SOC_EVT   = 6'd17;

  // per-core event lines
  typedef logic [3:0] evt_vec_t;

  localparam int unsigned EVT_TIMER = 0;
  localparam int unsigned EVT_DMA   = 1;
  localparam int unsigned EVT_SOC   = 2;
  localparam int unsigned EVT_SW    = 3;

  typedef logic [4:0] irq_id_t;

  localparam irq_id_t IRQ_ID_BASE    = 5'd16;
  localparam data_t   UNMAPPED_RDATA = 32'h0;

endpackage

/* hw/periph_bus_demux.sv */
/*
 * peripheral bus demux
 * decodes the unit select from the address, strobes one unit request
 * and returns the selected unit's read data one cycle later
 */
`timescale 1ns/1ps

module periph_bus_demux (
  input  logic                      clk_i,
  input  logic                      arst_n_i,

  input  logic                      periph_req_i,
  input  cluster_periph_pkg::addr_t periph_add_i,
  output logic                      periph_gnt_o,
  output logic                      periph_r_valid_o,
  output cluster_periph_pkg::data_t periph_r_rdata_o,

  output logic                      ctrl_req_o,
  output logic                      tmr_req_o,
  output logic                      eu_req_o,
  input  cluster_periph_pkg::data_t ctrl_rdata_i,
  input  cluster_periph_pkg::data_t tmr_rdata_i,
  input  cluster_periph_pkg::data_t eu_rdata_i
);
  import cluster_periph_pkg::*;

  unit_sel_t sel;
  unit_sel_t sel_q;
  logic      valid_q;

  assign sel = periph_add_i[UNIT_SEL_LSB +: $bits(unit_sel_t)];

  // single requester, every request is taken at once
  assign periph_gnt_o = periph_req_i;

  assign ctrl_req_o = periph_req_i && (sel == UNIT_CTRL);
  assign tmr_req_o  = periph_req_i && (sel == UNIT_TIMER);
  assign eu_req_o   = periph_req_i && (sel == UNIT_EU);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      sel_q   <= UNIT_CTRL;
    end else begin
      valid_q <= periph_req_i;
      if (periph_req_i) begin
        sel_q <= sel;
      end
    end
  end

  assign periph_r_valid_o = valid_q;

  // response mux follows the select captured with the request
  always_comb begin
    periph_r_rdata_o = '0;
    if (valid_q) begin
      case (sel_q)
        UNIT_CTRL:  periph_r_rdata_o = ctrl_rdata_i;
        UNIT_TIMER: periph_r_rdata_o = tmr_rdata_i;
        UNIT_EU:    periph_r_rdata_o = eu_rdata_i;
        default:    periph_r_rdata_o = UNMAPPED_RDATA;
      endcase
    end
  end

  // the unit decode needs a defined address with every request
  a_req_addr_known: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    periph_req_i |-> !$isunknown(periph_add_i)
  );

endmodule

/* hw/cluster_ctrl_unit.sv */
/*
 * cluster control unit
 * end-of-computation flag, per-core fetch enable and boot addresses
 */
`timescale 1ns/1ps

module cluster_ctrl_unit #(
  parameter int unsigned               NB_CORES      = 4,
  parameter cluster_periph_pkg::addr_t BOOT_ADDR     = 32'h1C00_0000,
  parameter cluster_periph_pkg::addr_t ROM_BOOT_ADDR = 32'h1A00_0000
) (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,

  input  logic                                     req_i,
  input  logic                                     wen_i,
  input  cluster_periph_pkg::reg_idx_t             idx_i,
  input  cluster_periph_pkg::data_t                wdata_i,
  output cluster_periph_pkg::data_t                rdata_o,

  input  logic                                     en_sa_boot_i,
  input  logic                                     fetch_en_i,
  output logic                                     eoc_o,
  output logic [NB_CORES-1:0]                      fetch_enable_o,
  output cluster_periph_pkg::addr_t [NB_CORES-1:0] boot_addr_o
);
  import cluster_periph_pkg::*;

  logic                 wr;
  logic                 eoc_q;
  logic [NB_CORES-1:0]  fetch_en_q;
  addr_t [NB_CORES-1:0] boot_addr_q;
  data_t                rd_data;
  data_t                rdata_q;

  assign wr = req_i && !wen_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      eoc_q       <= 1'b0;
      fetch_en_q  <= '0;
      boot_addr_q <= {NB_CORES{BOOT_ADDR}};
    end else if (wr) begin
      if (idx_i == CTRL_EOC) begin
        eoc_q <= wdata_i[0];
      end
      if (idx_i == CTRL_FETCH_EN) begin
        fetch_en_q <= wdata_i[NB_CORES-1:0];
      end
      for (int i = 0; i < NB_CORES; i++) begin
        if (idx_i == reg_idx_t'(CTRL_BOOT_BASE + i)) begin
          boot_addr_q[i] <= wdata_i;
        end
      end
    end
  end

  always_comb begin
    rd_data = '0;
    if (idx_i == CTRL_EOC) begin
      rd_data = data_t'(eoc_q);
    end
    if (idx_i == CTRL_FETCH_EN) begin
      rd_data = data_t'(fetch_en_q);
    end
    for (int i = 0; i < NB_CORES; i++) begin
      if (idx_i == reg_idx_t'(CTRL_BOOT_BASE + i)) begin
        rd_data = boot_addr_q[i];
      end
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= wen_i ? rd_data : '0;
    end
  end

  assign rdata_o = rdata_q;
  assign eoc_o   = eoc_q;

  // external fetch enable starts every core
  assign fetch_enable_o = fetch_en_q | {NB_CORES{fetch_en_i}};

  // standalone boot points all cores at the ROM, registers stay untouched
  always_comb begin
    for (int i = 0; i < NB_CORES; i++) begin
      boot_addr_o[i] = en_sa_boot_i ? ROM_BOOT_ADDR : boot_addr_q[i];
    end
  end

endmodule

/* hw/cluster_timer.sv */
/*
 * cluster timer
 * counts rising edges of the slow reference clock and pulses an
 * interrupt when the count hits the compare value
 */
`timescale 1ns/1ps

module cluster_timer (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic                         ref_clk_i,

  input  logic                         req_i,
  input  logic                         wen_i,
  input  cluster_periph_pkg::reg_idx_t idx_i,
  input  cluster_periph_pkg::data_t    wdata_i,
  output cluster_periph_pkg::data_t    rdata_o,

  output logic                         irq_o,
  output logic                         busy_o
);
  import cluster_periph_pkg::*;

  logic [1:0] ref_sync_q;
  logic       ref_prev_q;
  logic       tick;
  logic       wr;
  logic       en_q;
  data_t      cnt_q;
  data_t      cmp_q;
  logic       irq_q;
  data_t      rd_data;
  data_t      rdata_q;

  // two-flop synchronizer, then rising edge detect
  assign tick = ref_sync_q[1] && !ref_prev_q;
  assign wr   = req_i && !wen_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ref_sync_q <= '0;
      ref_prev_q <= 1'b0;
      en_q       <= 1'b0;
      cnt_q      <= '0;
      cmp_q      <= '0;
      irq_q      <= 1'b0;
    end else begin
      ref_sync_q <= {ref_sync_q[0], ref_clk_i};
      ref_prev_q <= ref_sync_q[1];
      irq_q      <= en_q && tick && (cnt_q == cmp_q);

      if (wr && idx_i == TMR_CFG) begin
        en_q <= wdata_i[0];
      end
      if (wr && idx_i == TMR_CMP) begin
        cmp_q <= wdata_i;
      end

      // a bus load of the count wins over a tick
      if (wr && idx_i == TMR_CNT) begin
        cnt_q <= wdata_i;
      end else if (en_q && tick) begin
        cnt_q <= (cnt_q == cmp_q) ? '0 : cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    case (idx_i)
      TMR_CFG: rd_data = data_t'(en_q);
      TMR_CNT: rd_data = cnt_q;
      TMR_CMP: rd_data = cmp_q;
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= wen_i ? rd_data : '0;
    end
  end

  assign rdata_o = rdata_q;
  assign irq_o   = irq_q;
  assign busy_o  = en_q;

  // the synchronizer must never sample an undefined reference clock
  a_ref_clk_known: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(ref_clk_i)
  );

endmodule

/* hw/event_unit.sv */
/*
 * event unit
 * buffers timer, DMA, SoC and software events per core, masks them
 * and raises interrupt requests cleared by an acknowledge
 */
`timescale 1ns/1ps

module event_unit #(
  parameter int unsigned NB_CORES   = 4,
  parameter int unsigned EVNT_WIDTH = 8
) (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,

  input  logic                                       req_i,
  input  logic                                       wen_i,
  input  cluster_periph_pkg::reg_idx_t               idx_i,
  input  cluster_periph_pkg::data_t                  wdata_i,
  output cluster_periph_pkg::data_t                  rdata_o,

  input  logic                                       timer_evt_i,
  input  logic [NB_CORES-1:0]                        dma_events_i,

  input  logic                                       soc_periph_evt_valid_i,
  output logic                                       soc_periph_evt_ready_o,
  input  logic [EVNT_WIDTH-1:0]                      soc_periph_evt_data_i,

  output logic [NB_CORES-1:0]                        irq_req_o,
  output cluster_periph_pkg::irq_id_t [NB_CORES-1:0] irq_id_o,
  input  logic [NB_CORES-1:0]                        irq_ack_i,
  input  cluster_periph_pkg::irq_id_t [NB_CORES-1:0] irq_ack_id_i
);
  import cluster_periph_pkg::*;

  logic                    wr;
  logic                    soc_rd;
  logic                    soc_accept;
  logic                    soc_full_q;
  logic [EVNT_WIDTH-1:0]   soc_data_q;
  evt_vec_t [NB_CORES-1:0] buf_q;
  evt_vec_t [NB_CORES-1:0] mask_q;
  evt_vec_t [NB_CORES-1:0] evt_set;
  evt_vec_t [NB_CORES-1:0] evt_clr;
  evt_vec_t [NB_CORES-1:0] pending;
  data_t                   rd_data;
  data_t                   rdata_q;

  assign wr         = req_i && !wen_i;
  assign soc_rd     = req_i && wen_i && (idx_i == EU_SOC_EVT);
  assign soc_accept = soc_periph_evt_valid_i && soc_periph_evt_ready_o;

  // single-entry SoC event register, held until software reads it
  assign soc_periph_evt_ready_o = !soc_full_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      soc_full_q <= 1'b0;
    end else if (soc_accept) begin
      soc_full_q <= 1'b1;
    end else if (soc_rd) begin
      soc_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (soc_accept) begin
      soc_data_q <= soc_periph_evt_data_i;
    end
  end

  // timer and SoC events go to every core, DMA and sw events per core
  always_comb begin
    for (int i = 0; i < NB_CORES; i++) begin
      evt_set[i]            = '0;
      evt_set[i][EVT_TIMER] = timer_evt_i;
      evt_set[i][EVT_DMA]   = dma_events_i[i];
      evt_set[i][EVT_SOC]   = soc_accept;
      evt_set[i][EVT_SW]    = wr && (idx_i == EU_SW_EVT) && wdata_i[i];

      evt_clr[i] = '0;
      if (wr && idx_i == reg_idx_t'(EU_BUF_BASE + i)) begin
        evt_clr[i] = wdata_i[$bits(evt_vec_t)-1:0];
      end
      for (int b = 0; b < $bits(evt_vec_t); b++) begin
        if (irq_ack_i[i] && irq_ack_id_i[i] == irq_id_t'(IRQ_ID_BASE + b)) begin
          evt_clr[i][b] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buf_q  <= '0;
      mask_q <= '0;
    end else begin
      for (int i = 0; i < NB_CORES; i++) begin
        // a new event wins over a clear in the same cycle
        buf_q[i] <= (buf_q[i] & ~evt_clr[i]) | evt_set[i];
        if (wr && idx_i == reg_idx_t'(EU_MASK_BASE + i)) begin
          mask_q[i] <= wdata_i[$bits(evt_vec_t)-1:0];
        end
      end
    end
  end

  // lowest pending bit has priority
  always_comb begin
    for (int i = 0; i < NB_CORES; i++) begin
      pending[i]   = buf_q[i] & mask_q[i];
      irq_req_o[i] = |pending[i];
      irq_id_o[i]  = IRQ_ID_BASE;
      for (int b = $bits(evt_vec_t) - 1; b >= 0; b--) begin
        if (pending[i][b]) begin
          irq_id_o[i] = irq_id_t'(IRQ_ID_BASE + b);
        end
      end
    end
  end

  always_comb begin
    rd_data = '0;
    if (idx_i == EU_SOC_EVT) begin
      rd_data = data_t'(soc_data_q);
    end
    for (int i = 0; i < NB_CORES; i++) begin
      if (idx_i == reg_idx_t'(EU_MASK_BASE + i)) begin
        rd_data = data_t'(mask_q[i]);
      end
      if (idx_i == reg_idx_t'(EU_BUF_BASE + i)) begin
        rd_data = data_t'(buf_q[i]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= wen_i ? rd_data : '0;
    end
  end

  assign rdata_o = rdata_q;

  for (genvar i = 0; i < NB_CORES; i++) begin : g_ack_check
    a_ack_with_req: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      irq_ack_i[i] |-> irq_req_o[i]
    );
  end

endmodule

/* hw/cluster_peripherals.sv */
/*
 * cluster peripherals
 * decodes the peripheral bus onto the control unit, the timer and
 * the event unit, and routes the timer interrupt into the event unit
 */
`timescale 1ns/1ps

module cluster_peripherals #(
  parameter int unsigned               NB_CORES      = 4,
  parameter int unsigned               EVNT_WIDTH    = 8,
  parameter cluster_periph_pkg::addr_t BOOT_ADDR     = 32'h1C00_0000,
  parameter cluster_periph_pkg::addr_t ROM_BOOT_ADDR = 32'h1A00_0000
) (
  input  logic                                       clk_i,
  input  logic                                       arst_n_i,
  input  logic                                       ref_clk_i,

  // peripheral bus, wen high is a read
  input  logic                                       periph_req_i,
  input  cluster_periph_pkg::addr_t                  periph_add_i,
  input  logic                                       periph_wen_i,
  input  cluster_periph_pkg::data_t                  periph_wdata_i,
  output logic                                       periph_gnt_o,
  output logic                                       periph_r_valid_o,
  output cluster_periph_pkg::data_t                  periph_r_rdata_o,

  input  logic                                       en_sa_boot_i,
  input  logic                                       fetch_en_i,
  output logic                                       eoc_o,
  output logic [NB_CORES-1:0]                        fetch_enable_o,
  output cluster_periph_pkg::addr_t [NB_CORES-1:0]   boot_addr_o,
  output logic                                       busy_o,

  input  logic [NB_CORES-1:0]                        dma_events_i,
  input  logic                                       soc_periph_evt_valid_i,
  output logic                                       soc_periph_evt_ready_o,
  input  logic [EVNT_WIDTH-1:0]                      soc_periph_evt_data_i,

  output logic [NB_CORES-1:0]                        irq_req_o,
  output cluster_periph_pkg::irq_id_t [NB_CORES-1:0] irq_id_o,
  input  logic [NB_CORES-1:0]                        irq_ack_i,
  input  cluster_periph_pkg::irq_id_t [NB_CORES-1:0] irq_ack_id_i
);
  import cluster_periph_pkg::*;

  reg_idx_t idx;
  logic     ctrl_req;
  logic     tmr_req;
  logic     eu_req;
  data_t    ctrl_rdata;
  data_t    tmr_rdata;
  data_t    eu_rdata;
  logic     timer_irq;

  // word index within the selected unit
  assign idx = periph_add_i[REG_IDX_LSB +: $bits(reg_idx_t)];

  periph_bus_demux u_periph_bus_demux (
    .clk_i            ( clk_i            ),
    .arst_n_i         ( arst_n_i         ),
    .periph_req_i     ( periph_req_i     ),
    .periph_add_i     ( periph_add_i     ),
    .periph_gnt_o     ( periph_gnt_o     ),
    .periph_r_valid_o ( periph_r_valid_o ),
    .periph_r_rdata_o ( periph_r_rdata_o ),
    .ctrl_req_o       ( ctrl_req         ),
    .tmr_req_o        ( tmr_req          ),
    .eu_req_o         ( eu_req           ),
    .ctrl_rdata_i     ( ctrl_rdata       ),
    .tmr_rdata_i      ( tmr_rdata        ),
    .eu_rdata_i       ( eu_rdata         )
  );

  cluster_ctrl_unit #(
    .NB_CORES      ( NB_CORES      ),
    .BOOT_ADDR     ( BOOT_ADDR     ),
    .ROM_BOOT_ADDR ( ROM_BOOT_ADDR )
  ) u_cluster_ctrl_unit (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .req_i          ( ctrl_req       ),
    .wen_i          ( periph_wen_i   ),
    .idx_i          ( idx            ),
    .wdata_i        ( periph_wdata_i ),
    .rdata_o        ( ctrl_rdata     ),
    .en_sa_boot_i   ( en_sa_boot_i   ),
    .fetch_en_i     ( fetch_en_i     ),
    .eoc_o          ( eoc_o          ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  cluster_timer u_cluster_timer (
    .clk_i     ( clk_i          ),
    .arst_n_i  ( arst_n_i       ),
    .ref_clk_i ( ref_clk_i      ),
    .req_i     ( tmr_req        ),
    .wen_i     ( periph_wen_i   ),
    .idx_i     ( idx            ),
    .wdata_i   ( periph_wdata_i ),
    .rdata_o   ( tmr_rdata      ),
    .irq_o     ( timer_irq      ),
    .busy_o    ( busy_o         )
  );

  event_unit #(
    .NB_CORES   ( NB_CORES   ),
    .EVNT_WIDTH ( EVNT_WIDTH )
  ) u_event_unit (
    .clk_i                  ( clk_i                  ),
    .arst_n_i               ( arst_n_i               ),
    .req_i                  ( eu_req                 ),
    .wen_i                  ( periph_wen_i           ),
    .idx_i                  ( idx                    ),
    .wdata_i                ( periph_wdata_i         ),
    .rdata_o                ( eu_rdata               ),
    .timer_evt_i            ( timer_irq              ),
    .dma_events_i           ( dma_events_i           ),
    .soc_periph_evt_valid_i ( soc_periph_evt_valid_i ),
    .soc_periph_evt_ready_o ( soc_periph_evt_ready_o ),
    .soc_periph_evt_data_i  ( soc_periph_evt_data_i  ),
    .irq_req_o              ( irq_req_o              ),
    .irq_id_o               ( irq_id_o               ),
    .irq_ack_i              ( irq_ack_i              ),
    .irq_ack_id_i           ( irq_ack_id_i           )
  );

endmodule

/* verif/tb_cluster_peripherals.sv */
/*
 * cluster peripherals testbench
 * runs a table of bus accesses, then control, timer, interrupt and
 * SoC event scenarios against expected values and reports the counts
 */
`timescale 1ns/1ps

module tb_cluster_peripherals;
  import cluster_periph_pkg::*;

  localparam int unsigned NB_CORES      = 4;
  localparam int unsigned EVNT_WIDTH    = 8;
  localparam addr_t       BOOT_ADDR     = 32'h1C00_8080;
  localparam addr_t       ROM_BOOT_ADDR = 32'h1A00_0000;
  localparam int          TBL_SIZE      = 16;
  localparam data_t       FETCH_VAL     = 32'h5;
  localparam data_t       TIMER_CMP     = 32'd3;
  localparam int          TIMER_POLLS   = 40;
  localparam int          SOC_WAIT      = 20;

  logic                         clk;
  logic                         arst_n;
  logic                         ref_clk;
  logic                         req;
  addr_t                        add;
  logic                         wen;
  data_t                        wdata;
  logic                         gnt;
  logic                         r_valid;
  data_t                        r_rdata;
  logic                         en_sa_boot;
  logic                         fetch_en;
  logic                         eoc;
  logic [NB_CORES-1:0]          fetch_enable;
  addr_t [NB_CORES-1:0]         boot_addr;
  logic                         busy;
  logic [NB_CORES-1:0]          dma_events;
  logic                         soc_valid;
  logic                         soc_ready;
  logic [EVNT_WIDTH-1:0]        soc_data;
  logic [NB_CORES-1:0]          irq_req;
  irq_id_t [NB_CORES-1:0]       irq_id;
  logic [NB_CORES-1:0]          irq_ack;
  irq_id_t [NB_CORES-1:0]       irq_ack_id;

  // bus operation table
  logic      tbl_rd    [TBL_SIZE];
  unit_sel_t tbl_unit  [TBL_SIZE];
  reg_idx_t  tbl_idx   [TBL_SIZE];
  data_t     tbl_wdata [TBL_SIZE];
  data_t     tbl_exp   [TBL_SIZE];
  int        tbl_len;
  data_t     boot_rand [NB_CORES];

  // reference model of the event unit state
  evt_vec_t  exp_buf  [NB_CORES];
  evt_vec_t  exp_mask [NB_CORES];

  int checks;
  int errors;
  int test_checks;
  int test_errors;

  cluster_peripherals #(
    .NB_CORES      ( NB_CORES      ),
    .EVNT_WIDTH    ( EVNT_WIDTH    ),
    .BOOT_ADDR     ( BOOT_ADDR     ),
    .ROM_BOOT_ADDR ( ROM_BOOT_ADDR )
  ) u_cluster_peripherals (
    .clk_i                  ( clk          ),
    .arst_n_i               ( arst_n       ),
    .ref_clk_i              ( ref_clk      ),
    .periph_req_i           ( req          ),
    .periph_add_i           ( add          ),
    .periph_wen_i           ( wen          ),
    .periph_wdata_i         ( wdata        ),
    .periph_gnt_o           ( gnt          ),
    .periph_r_valid_o       ( r_valid      ),
    .periph_r_rdata_o       ( r_rdata      ),
    .en_sa_boot_i           ( en_sa_boot   ),
    .fetch_en_i             ( fetch_en     ),
    .eoc_o                  ( eoc          ),
    .fetch_enable_o         ( fetch_enable ),
    .boot_addr_o            ( boot_addr    ),
    .busy_o                 ( busy         ),
    .dma_events_i           ( dma_events   ),
    .soc_periph_evt_valid_i ( soc_valid    ),
    .soc_periph_evt_ready_o ( soc_ready    ),
    .soc_periph_evt_data_i  ( soc_data     ),
    .irq_req_o              ( irq_req      ),
    .irq_id_o               ( irq_id       ),
    .irq_ack_i              ( irq_ack      ),
    .irq_ack_id_i           ( irq_ack_id   )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // slow reference clock, one rising edge every 10 cycles
  initial begin
    ref_clk = 1'b0;
    forever begin
      repeat (5) @(posedge clk);
      #2 ref_clk = ~ref_clk;
    end
  end

  task automatic check_value(input string name, input data_t got, input data_t exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %s got 0x%08h expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("failure: %s", what);
    end
  endtask

  task automatic begin_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    $display("test %-14s checks %0d errors %0d", name, checks - test_checks,
             errors - test_errors);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic add_entry(input logic rd, input unit_sel_t unit, input reg_idx_t idx,
                           input data_t wd, input data_t exp);
    tbl_rd[tbl_len]    = rd;
    tbl_unit[tbl_len]  = unit;
    tbl_idx[tbl_len]   = idx;
    tbl_wdata[tbl_len] = wd;
    tbl_exp[tbl_len]   = exp;
    tbl_len++;
  endtask

  // one access, granted at once, answered exactly one cycle later
  task automatic bus_access(input logic rd, input unit_sel_t unit, input reg_idx_t idx,
                            input data_t wd, output data_t rdata);
    next_cycle();
    check_true(!r_valid, "r_valid high without a request in the previous cycle");
    req   = 1'b1;
    add   = {20'h0, unit, 2'b00, idx, 2'b00};
    wen   = rd;
    wdata = wd;
    #1;
    check_true(gnt, "request not granted in its own cycle");
    next_cycle();
    req = 1'b0;
    check_true(r_valid, "r_valid missing one cycle after the grant");
    rdata = r_rdata;
  endtask

  function automatic irq_id_t expected_id(input evt_vec_t pend);
    irq_id_t id;
    logic    found;
    id    = IRQ_ID_BASE;
    found = 1'b0;
    for (int b = 0; b < $bits(evt_vec_t); b++) begin
      if (!found && pend[b]) begin
        id    = IRQ_ID_BASE + irq_id_t'(b);
        found = 1'b1;
      end
    end
    return id;
  endfunction

  task automatic check_irqs();
    evt_vec_t pend;
    for (int i = 0; i < NB_CORES; i++) begin
      pend = exp_buf[i] & exp_mask[i];
      check_value($sformatf("irq_req_o[%0d]", i), data_t'(irq_req[i]), data_t'(|pend));
      if (|pend) begin
        check_value($sformatf("irq_id_o[%0d]", i), data_t'(irq_id[i]),
                    data_t'(expected_id(pend)));
      end
    end
  endtask

  // acknowledge the lowest pending interrupt of one core
  task automatic ack_irq(input int core);
    irq_id_t id;
    id = expected_id(exp_buf[core] & exp_mask[core]);
    next_cycle();
    irq_ack[core]    = 1'b1;
    irq_ack_id[core] = id;
    next_cycle();
    irq_ack = '0;
    exp_buf[core][int'(id) - int'(IRQ_ID_BASE)] = 1'b0;
  endtask

  task automatic wait_ready(input logic level, output logic ok);
    ok = 1'b0;
    for (int t = 0; t < SOC_WAIT && !ok; t++) begin
      next_cycle();
      ok = (soc_ready == level);
    end
  endtask

  task automatic wait_timer_all_cores(output logic seen);
    data_t               rd;
    logic [NB_CORES-1:0] hits;
    seen = 1'b0;
    for (int t = 0; t < TIMER_POLLS && !seen; t++) begin
      for (int i = 0; i < NB_CORES; i++) begin
        bus_access(1'b1, UNIT_EU, reg_idx_t'(EU_BUF_BASE + i), '0, rd);
        hits[i] = rd[EVT_TIMER];
      end
      seen = &hits;
    end
  endtask

  initial begin
    data_t rd;
    logic  ok;

    arst_n     = 1'b0;
    req        = 1'b0;
    add        = '0;
    wen        = 1'b1;
    wdata      = '0;
    en_sa_boot = 1'b0;
    fetch_en   = 1'b0;
    dma_events = '0;
    soc_valid  = 1'b0;
    soc_data   = '0;
    irq_ack    = '0;
    irq_ack_id = '0;
    checks     = 0;
    errors     = 0;
    tbl_len    = 0;
    void'($urandom(32'h371d_956d));
    for (int i = 0; i < NB_CORES; i++) begin
      boot_rand[i] = $urandom;
      exp_buf[i]   = '0;
      exp_mask[i]  = '0;
    end

    add_entry(1'b1, UNIT_CTRL, CTRL_BOOT_BASE, '0, BOOT_ADDR);
    add_entry(1'b1, UNIT_CTRL, reg_idx_t'(CTRL_BOOT_BASE + 3), '0, BOOT_ADDR);
    for (int i = 0; i < NB_CORES; i++) begin
      add_entry(1'b0, UNIT_CTRL, reg_idx_t'(CTRL_BOOT_BASE + i), boot_rand[i], '0);
    end
    for (int i = 0; i < NB_CORES; i++) begin
      add_entry(1'b1, UNIT_CTRL, reg_idx_t'(CTRL_BOOT_BASE + i), '0, boot_rand[i]);
    end
    add_entry(1'b0, UNIT_CTRL, CTRL_FETCH_EN, FETCH_VAL, '0);
    add_entry(1'b1, UNIT_CTRL, CTRL_FETCH_EN, '0, FETCH_VAL);
    add_entry(1'b0, unit_sel_t'(3), 6'd1, $urandom, '0);
    add_entry(1'b1, unit_sel_t'(3), 6'd1, '0, UNMAPPED_RDATA);
    add_entry(1'b0, UNIT_TIMER, TMR_CMP, 32'h0000_1234, '0);
    add_entry(1'b1, UNIT_TIMER, TMR_CMP, '0, 32'h0000_1234);

    repeat (2) @(posedge clk);
    #2 arst_n = 1'b1;

    begin_test();
    check_value("periph_r_valid_o", data_t'(r_valid), '0);
    check_value("irq_req_o", data_t'(irq_req), '0);
    check_value("eoc_o", data_t'(eoc), '0);
    check_value("fetch_enable_o", data_t'(fetch_enable), '0);
    check_value("busy_o", data_t'(busy), '0);
    check_value("soc_periph_evt_ready_o", data_t'(soc_ready), 32'h1);
    end_test("reset");

    begin_test();
    for (int n = 0; n < tbl_len; n++) begin
      bus_access(tbl_rd[n], tbl_unit[n], tbl_idx[n], tbl_wdata[n], rd);
      check_value($sformatf("periph_r_rdata_o entry %0d", n), rd, tbl_exp[n]);
    end
    end_test("bus table");

    begin_test();
    check_value("fetch_enable_o", data_t'(fetch_enable), FETCH_VAL);
    next_cycle();
    fetch_en = 1'b1;
    #1;
    check_value("fetch_enable_o", data_t'(fetch_enable), 32'hF);
    next_cycle();
    fetch_en   = 1'b0;
    en_sa_boot = 1'b1;
    #1;
    for (int i = 0; i < NB_CORES; i++) begin
      check_value($sformatf("boot_addr_o[%0d]", i), boot_addr[i], ROM_BOOT_ADDR);
    end
    // registers keep their own values under standalone boot
    bus_access(1'b1, UNIT_CTRL, reg_idx_t'(CTRL_BOOT_BASE + 1), '0, rd);
    check_value("periph_r_rdata_o", rd, boot_rand[1]);
    en_sa_boot = 1'b0;
    #1;
    for (int i = 0; i < NB_CORES; i++) begin
      check_value($sformatf("boot_addr_o[%0d]", i), boot_addr[i], boot_rand[i]);
    end
    bus_access(1'b0, UNIT_CTRL, CTRL_EOC, 32'h1, rd);
    check_value("eoc_o", data_t'(eoc), 32'h1);
    end_test("control");

    begin_test();
    bus_access(1'b0, UNIT_TIMER, TMR_CMP, TIMER_CMP, rd);
    bus_access(1'b0, UNIT_TIMER, TMR_CNT, '0, rd);
    bus_access(1'b0, UNIT_TIMER, TMR_CFG, 32'h1, rd);
    check_value("busy_o", data_t'(busy), 32'h1);
    wait_timer_all_cores(ok);
    check_true(ok, "timer event did not reach every core before the timeout");
    bus_access(1'b0, UNIT_TIMER, TMR_CFG, '0, rd);
    check_value("busy_o", data_t'(busy), '0);
    bus_access(1'b1, UNIT_TIMER, TMR_CNT, '0, rd);
    check_true(rd < TIMER_CMP, "timer count did not wrap after the compare match");
    end_test("timer");

    begin_test();
    for (int i = 0; i < NB_CORES; i++) begin
      bus_access(1'b0, UNIT_EU, reg_idx_t'(EU_BUF_BASE + i), 32'hF, rd);
    end
    exp_mask[0] = 4'b1010;
    exp_mask[1] = 4'b1000;
    exp_mask[3] = 4'b0010;
    for (int i = 0; i < NB_CORES; i++) begin
      bus_access(1'b0, UNIT_EU, reg_idx_t'(EU_MASK_BASE + i), data_t'(exp_mask[i]), rd);
    end
    check_irqs();
    next_cycle();
    dma_events = 4'b0011;
    next_cycle();
    dma_events = '0;
    exp_buf[0][EVT_DMA] = 1'b1;
    exp_buf[1][EVT_DMA] = 1'b1;
    bus_access(1'b0, UNIT_EU, EU_SW_EVT, 32'h5, rd);
    exp_buf[0][EVT_SW] = 1'b1;
    exp_buf[2][EVT_SW] = 1'b1;
    for (int i = 0; i < NB_CORES; i++) begin
      bus_access(1'b1, UNIT_EU, reg_idx_t'(EU_BUF_BASE + i), '0, rd);
      check_value($sformatf("periph_r_rdata_o buffer %0d", i), rd, data_t'(exp_buf[i]));
    end
    check_irqs();
    ack_irq(0);
    check_irqs();
    ack_irq(0);
    check_irqs();
    // unmasking the DMA bit of core 1 raises its request
    exp_mask[1] = 4'b0010;
    bus_access(1'b0, UNIT_EU, reg_idx_t'(EU_MASK_BASE + 1), data_t'(exp_mask[1]), rd);
    check_irqs();
    ack_irq(1);
    check_irqs();
    end_test("irq");

    begin_test();
    next_cycle();
    soc_valid = 1'b1;
    soc_data  = 8'hA5;
    wait_ready(1'b0, ok);
    check_true(ok, "first SoC event was not accepted before the timeout");
    soc_data = 8'h3C;
    repeat (3) begin
      next_cycle();
      check_true(!soc_ready, "ready rose while the SoC event register was full");
    end
    bus_access(1'b1, UNIT_EU, EU_SOC_EVT, '0, rd);
    check_value("periph_r_rdata_o", rd, 32'h0000_00A5);
    check_value("soc_periph_evt_ready_o", data_t'(soc_ready), 32'h1);
    wait_ready(1'b0, ok);
    check_true(ok, "second SoC event was not accepted before the timeout");
    soc_valid = 1'b0;
    bus_access(1'b1, UNIT_EU, EU_SOC_EVT, '0, rd);
    check_value("periph_r_rdata_o", rd, 32'h0000_003C);
    check_value("soc_periph_evt_ready_o", data_t'(soc_ready), 32'h1);
    end_test("soc event");

    $display("total checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* tb.f */
hw/cluster_periph_pkg.sv
hw/periph_bus_demux.sv
hw/cluster_ctrl_unit.sv
hw/cluster_timer.sv
hw/event_unit.sv
hw/cluster_peripherals.sv
verif/tb_cluster_peripherals.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cluster_peripherals
FILELIST = tb.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
